// ==== common/load_macros.svh ====
`ifndef LOAD_MACROS_SVH
`define LOAD_MACROS_SVH

// data word width of the core
`define XLEN 64

// width of the id that tags each load through the pipeline
`define TRANS_ID_BITS 3

// virtual and physical address widths
`define VADDR_WIDTH 32
`define PADDR_WIDTH 34

// cache index width, which is also the page offset width
`define INDEX_WIDTH 12
`define TAG_WIDTH 22

// entries in the request buffer and credits the producer starts with
`define REQ_DEPTH 4

`endif

// ==== common/load_pkg.sv ====
`default_nettype none

`include "load_macros.svh"

package load_pkg;

    // ---------------------------------------------------------------------------
    // plain vector types
    // ---------------------------------------------------------------------------
    typedef logic [`XLEN-1:0]          xlen_t;
    typedef logic [`TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [`VADDR_WIDTH-1:0]   vaddr_t;
    typedef logic [`PADDR_WIDTH-1:0]   paddr_t;
    typedef logic [`INDEX_WIDTH-1:0]   index_t;
    typedef logic [`TAG_WIDTH-1:0]     tag_t;
    // byte position of the access inside a 64-bit word
    typedef logic [2:0]                byte_off_t;

    // the seven integer loads, the U variants zero-extend
    typedef enum logic [2:0] {
        LD, LW, LWU, LH, LHU, LB, LBU
    } load_op_e;

    // states of the load request controller
    typedef enum logic [2:0] {
        IDLE, WAIT_PAGE_OFFSET, WAIT_GNT, SEND_TAG, ABORT, WAIT_TRANSLATION
    } ld_state_e;

    // ---------------------------------------------------------------------------
    // port structs
    // ---------------------------------------------------------------------------
    typedef struct packed {
        trans_id_t trans_id;
        vaddr_t    vaddr;
        load_op_e  op;
    } load_req_t;

    // read-only cache request, the tag phase follows the granted index phase
    typedef struct packed {
        logic       data_req;
        index_t     address_index;
        tag_t       address_tag;
        logic       tag_valid;
        logic       kill_req;
        logic [1:0] data_size;
    } dcache_req_t;

    typedef struct packed {
        logic  data_gnt;
        logic  data_rvalid;
        xlen_t data_rdata;
    } dcache_rsp_t;

    typedef struct packed {
        logic      valid;
        trans_id_t trans_id;
        xlen_t     result;
    } load_rsp_t;

endpackage

`default_nettype wire

// ==== load_ctrl/load_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "load_macros.svh"

module load_ctrl_fsm
    import load_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    // head of the request buffer
    input  logic        head_valid_i,
    input  load_req_t   head_i,
    output logic        pop_o,
    // address translation
    output logic        translation_req_o,
    output vaddr_t      vaddr_o,
    input  logic        dtlb_hit_i,
    input  paddr_t      paddr_i,
    // store alias check on the page offset
    output index_t      page_offset_o,
    input  logic        page_offset_matches_i,
    // data cache
    output dcache_req_t dcache_req_o,
    input  logic        dcache_gnt_i
);

    ld_state_e  state_d;
    ld_state_e  state_q;
    tag_t       tag_q;
    logic       issue;
    logic       req_phase;
    logic       data_req;
    logic       tag_valid;
    logic       kill_req;
    logic [1:0] data_size;

    // the head address always goes to the TLB and to the alias check
    assign vaddr_o       = head_i.vaddr;
    assign page_offset_o = head_i.vaddr[`INDEX_WIDTH-1:0];

    // a new head may start from idle, or right behind the tag of the previous load
    assign issue     = head_valid_i && (state_q inside {IDLE, SEND_TAG});
    // cycles that present the index to the cache and wait for its grant
    assign req_phase = (state_q == WAIT_GNT) || (issue && !page_offset_matches_i);

    // access size in log2 bytes, as the cache expects it
    always_comb begin
        case (head_i.op)
            LW, LWU: data_size = 2'd2;
            LH, LHU: data_size = 2'd1;
            LB, LBU: data_size = 2'd0;
            default: data_size = 2'd3;
        endcase
    end

    // ---------------------------------------------------------------------------
    // request control
    // ---------------------------------------------------------------------------
    always_comb begin
        state_d           = state_q;
        translation_req_o = 1'b0;
        data_req          = 1'b0;
        tag_valid         = 1'b0;
        kill_req          = 1'b0;
        pop_o             = 1'b0;

        case (state_q)
            // a store still aliases the offset, so the index is held back
            WAIT_PAGE_OFFSET: begin
                if (!page_offset_matches_i) begin
                    state_d = WAIT_GNT;
                end
            end
            // the translation from the grant cycle was good, so the latched tag goes out
            SEND_TAG: begin
                tag_valid = 1'b1;
                state_d   = IDLE;
            end
            // the TLB missed at grant, so the index phase is killed in the tag slot
            ABORT: begin
                tag_valid = 1'b1;
                kill_req  = 1'b1;
                state_d   = WAIT_TRANSLATION;
            end
            // keep asking until the page walk has refilled the TLB
            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end
            default: begin
                state_d = state_q;
            end
        endcase

        // translation starts together with the alias check to keep the path short
        if (issue) begin
            translation_req_o = 1'b1;
            if (page_offset_matches_i) begin
                state_d = WAIT_PAGE_OFFSET;
            end
        end

        // the index stays up until the grant, then the TLB answer picks the next step
        if (req_phase) begin
            translation_req_o = 1'b1;
            data_req          = 1'b1;
            if (!dcache_gnt_i) begin
                state_d = WAIT_GNT;
            end else if (dtlb_hit_i) begin
                state_d = SEND_TAG;
                pop_o   = 1'b1;
            end else begin
                state_d = ABORT;
            end
        end
    end

    // the tag is sent one cycle after the grant, so it comes from a register
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            tag_q <= paddr_i[`TAG_WIDTH+`INDEX_WIDTH-1:`INDEX_WIDTH];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign dcache_req_o = '{
        data_req:      data_req,
        address_index: head_i.vaddr[`INDEX_WIDTH-1:0],
        address_tag:   tag_q,
        tag_valid:     tag_valid,
        kill_req:      kill_req,
        data_size:     data_size
    };

    // a tag phase, killed or not, only ever closes an index phase the cache granted
    a_tag_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tag_valid |-> $past(data_req && dcache_gnt_i))
        else $error("tag_valid without a granted index phase");

endmodule

`default_nettype wire

// ==== rtl/load_req_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "load_macros.svh"

module load_req_buffer
    import load_pkg::*;
#(
    parameter int unsigned depth = `REQ_DEPTH
) (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      req_valid_i,
    input  load_req_t req_i,
    input  logic      pop_i,
    output logic      head_valid_o,
    output load_req_t head_o,
    output logic      credit_o
);

    localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int unsigned cnt_w = $clog2(depth + 1);

    typedef logic [ptr_w-1:0] ptr_t;

    load_req_t        mem_q [depth];
    ptr_t             rd_ptr_q;
    ptr_t             wr_ptr_q;
    logic [cnt_w-1:0] count_q;
    logic             empty;
    logic             full;
    logic             push;
    logic             pop;

    // pointers wrap explicitly so the depth need not be a power of two
    function automatic ptr_t next_ptr(ptr_t ptr);
        return (ptr == ptr_t'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count_q == '0);
    assign full  = (count_q == cnt_w'(depth));
    // the producer only pushes while it holds a credit, so full never sees a push
    assign push  = req_valid_i && !full;
    assign pop   = pop_i && !empty;

    // the head is read straight from the array and is visible the cycle after its push
    assign head_valid_o = !empty;
    assign head_o       = mem_q[rd_ptr_q];
    // every accepted head frees one slot, which goes back to the producer at once
    assign credit_o     = pop;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // a push into a full buffer means the producer spent a credit it did not hold
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i |-> !full)
        else $error("load request pushed without a credit");

    // the controller may only accept a head that is actually there
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty)
        else $error("load request popped from an empty buffer");

endmodule

`default_nettype wire

// ==== rtl/load_result_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "load_macros.svh"

module load_result_align
    import load_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      pop_i,
    input  load_req_t head_i,
    input  logic      rvalid_i,
    input  xlen_t     rdata_i,
    output load_rsp_t rsp_o
);

    // what the data phase needs to know about a load, taken when it leaves the buffer
    typedef struct packed {
        trans_id_t trans_id;
        byte_off_t offset;
        load_op_e  op;
        byte_off_t sign_idx;
        logic      is_signed;
    } ld_meta_t;

    ld_meta_t          meta_d;
    ld_meta_t          meta_q [2];
    ld_meta_t          cur;
    logic              wr_sel_q;
    logic              rd_sel_q;
    logic [1:0]        pending_q;
    logic [`XLEN/8-1:0] sign_bits;
    logic              sign_bit;
    xlen_t             shifted;
    xlen_t             result;

    // the byte holding the sign is worked out at pop, off the data path
    always_comb begin
        meta_d.trans_id  = head_i.trans_id;
        meta_d.offset    = head_i.vaddr[2:0];
        meta_d.op        = head_i.op;
        meta_d.is_signed = head_i.op inside {LW, LH, LB};
        case (head_i.op)
            LW, LWU: meta_d.sign_idx = head_i.vaddr[2:0] + 3'd3;
            LH, LHU: meta_d.sign_idx = head_i.vaddr[2:0] + 3'd1;
            default: meta_d.sign_idx = head_i.vaddr[2:0];
        endcase
    end

    // a load popped behind a sent tag must not overwrite the one still waiting for data,
    // so the capture alternates between two slots
    always_ff @(posedge clk_i) begin
        if (pop_i) begin
            meta_q[wr_sel_q] <= meta_d;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_sel_q  <= 1'b0;
            rd_sel_q  <= 1'b0;
            pending_q <= '0;
        end else begin
            if (pop_i) begin
                wr_sel_q <= ~wr_sel_q;
            end
            if (rvalid_i) begin
                rd_sel_q <= ~rd_sel_q;
            end
            case ({pop_i, rvalid_i})
                2'b10:   pending_q <= pending_q + 1'b1;
                2'b01:   pending_q <= pending_q - 1'b1;
                default: pending_q <= pending_q;
            endcase
        end
    end

    // data returns in issue order, so the oldest slot belongs to this rvalid
    assign cur = meta_q[rd_sel_q];

    // ---------------------------------------------------------------------------
    // realign and extend
    // ---------------------------------------------------------------------------
    assign shifted = rdata_i >> {cur.offset, 3'b000};

    // top bit of every byte, so the sign select runs beside the shifter
    for (genvar i = 0; i < `XLEN / 8; i++) begin : gen_sign_bits
        assign sign_bits[i] = rdata_i[8*i+7];
    end

    // unsigned loads pull the sign to zero
    assign sign_bit = cur.is_signed & sign_bits[cur.sign_idx];

    always_comb begin
        case (cur.op)
            LW, LWU: result = {{(`XLEN-32){sign_bit}}, shifted[31:0]};
            LH, LHU: result = {{(`XLEN-16){sign_bit}}, shifted[15:0]};
            LB, LBU: result = {{(`XLEN-8){sign_bit}}, shifted[7:0]};
            default: result = shifted;
        endcase
    end

    assign rsp_o = '{valid: rvalid_i, trans_id: cur.trans_id, result: result};

    // the cache only returns data for loads the controller has accepted and not killed
    a_rvalid_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i |-> (pending_q != '0))
        else $error("rvalid without an outstanding load");

    // natural alignment of the access that the data belongs to
    a_half_align: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i && (cur.op inside {LH, LHU}) |-> (cur.offset[0] == 1'b0))
        else $error("misaligned halfword load");
    a_word_align: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i && (cur.op inside {LW, LWU}) |-> (cur.offset[1:0] == 2'b00))
        else $error("misaligned word load");
    a_dword_align: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i && (cur.op == LD) |-> (cur.offset == 3'd0))
        else $error("misaligned doubleword load");

endmodule

`default_nettype wire

// ==== rtl/load_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_unit_top
    import load_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    // credit-controlled request port
    input  logic        req_valid_i,
    input  load_req_t   req_i,
    output logic        credit_o,
    // address translation
    output logic        translation_req_o,
    output vaddr_t      vaddr_o,
    input  logic        dtlb_hit_i,
    input  paddr_t      paddr_i,
    // store alias check
    output index_t      page_offset_o,
    input  logic        page_offset_matches_i,
    // data cache
    output dcache_req_t dcache_req_o,
    input  dcache_rsp_t dcache_rsp_i,
    // results, never back-pressured
    output load_rsp_t   rsp_o
);

    logic      head_valid;
    load_req_t head;
    logic      pop;

    // requests wait here until the controller can issue them
    load_req_buffer u_load_req_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_o       (head),
        .credit_o     (credit_o)
    );

    load_ctrl_fsm u_load_ctrl_fsm (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .head_valid_i          (head_valid),
        .head_i                (head),
        .pop_o                 (pop),
        .translation_req_o     (translation_req_o),
        .vaddr_o               (vaddr_o),
        .dtlb_hit_i            (dtlb_hit_i),
        .paddr_i               (paddr_i),
        .page_offset_o         (page_offset_o),
        .page_offset_matches_i (page_offset_matches_i),
        .dcache_req_o          (dcache_req_o),
        .dcache_gnt_i          (dcache_rsp_i.data_gnt)
    );

    // the popped head is captured here and paired with its returning word
    load_result_align u_load_result_align (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .pop_i    (pop),
        .head_i   (head),
        .rvalid_i (dcache_rsp_i.data_rvalid),
        .rdata_i  (dcache_rsp_i.data_rdata),
        .rsp_o    (rsp_o)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# builds the load unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f src.f --top-module tb_load_unit -o sim_load_unit
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_load_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi

if ! grep -q "TEST PASSED" sim.log; then
    echo "simulation log holds no result line"
    exit 1
fi

exit 0

// ==== src.f ====
+incdir+common
common/load_pkg.sv
rtl/load_req_buffer.sv
load_ctrl/load_ctrl_fsm.sv
rtl/load_result_align.sv
rtl/load_unit_top.sv
tb/load_checker.sv
tb/tb_load_unit.sv

// ==== tb/load_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "load_macros.svh"

module load_checker
    import load_pkg::*;
#(
    parameter int n_lines = 1
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        req_valid_i,
    input  logic        credit_i,
    input  logic        translation_req_i,
    input  vaddr_t      vaddr_i,
    input  index_t      page_offset_i,
    input  dcache_req_t dcache_req_i,
    input  logic        page_offset_matches_i,
    input  load_rsp_t   rsp_i,
    input  vaddr_t      addr_i [n_lines],
    input  logic [2:0]  op_i [n_lines],
    input  xlen_t       expected_i [n_lines],
    input  int          expected_kills_i,
    output logic        done_o,
    output int          error_count_o
);

    int errors;
    int rsp_cnt;
    int kills;
    int outstanding;
    int pops;
    int tags;
    logic ok;

    assign done_o        = (rsp_cnt == n_lines);
    assign error_count_o = errors;

    // access size in log2 bytes for the op encoding of the data file
    function automatic logic [1:0] size_of_op(logic [2:0] op);
        case (op)
            3'd0:       return 2'd3;
            3'd1, 3'd2: return 2'd2;
            3'd3, 3'd4: return 2'd1;
            default:    return 2'd0;
        endcase
    endfunction

    initial begin
        errors      = 0;
        rsp_cnt     = 0;
        kills       = 0;
        outstanding = 0;
        pops        = 0;
        tags        = 0;
    end

    // ------------------------------------------------------------------------
    // per-cycle protocol and result checks
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (rst_ni) begin
            // credits in use by the producer, pushes minus returned credits
            outstanding = outstanding + int'(req_valid_i) - int'(credit_i);
            if (outstanding > `REQ_DEPTH) begin
                $display("more than %0d requests were pushed without a credit", `REQ_DEPTH);
                errors++;
            end
            if (outstanding < 0) begin
                $display("a credit came back for a request that was never pushed");
                errors++;
            end
            // the head of the buffer is the oldest line not yet popped
            if (pops < n_lines) begin
                if (translation_req_i && ((vaddr_i != addr_i[pops]) ||
                        (page_offset_i != addr_i[pops][`INDEX_WIDTH-1:0]))) begin
                    $display("Error at %0t ns: test %0d translation vaddr %h offset %h",
                             $time, pops, vaddr_i, page_offset_i);
                    errors++;
                end
                if (dcache_req_i.data_req &&
                        ((dcache_req_i.address_index != addr_i[pops][`INDEX_WIDTH-1:0]) ||
                         (dcache_req_i.data_size != size_of_op(op_i[pops])))) begin
                    $display("Error at %0t ns: test %0d cache index %h size %0d",
                             $time, pops, dcache_req_i.address_index,
                             dcache_req_i.data_size);
                    errors++;
                end
            end
            if (credit_i) begin
                pops++;
            end
            // a store aliasing the page offset must hold the index back
            if (dcache_req_i.data_req && page_offset_matches_i) begin
                $display("Error at %0t ns: data_req raised during a page offset stall", $time);
                errors++;
            end
            if (dcache_req_i.tag_valid && dcache_req_i.kill_req) begin
                kills++;
            end
            // the TLB model maps vaddr to the same paddr, so the tag is the upper vaddr
            if (dcache_req_i.tag_valid && !dcache_req_i.kill_req) begin
                if ((tags < n_lines) &&
                        (dcache_req_i.address_tag != tag_t'(addr_i[tags] >> `INDEX_WIDTH))) begin
                    $display("Error at %0t ns: test %0d cache tag %h",
                             $time, tags, dcache_req_i.address_tag);
                    errors++;
                end
                tags++;
            end
            if (rsp_i.valid) begin
                if (rsp_cnt >= n_lines) begin
                    $display("a response arrived after all loads had completed");
                    errors++;
                end else begin
                    // responses come back in request order, so the id is the line index
                    ok = (rsp_i.trans_id == trans_id_t'(rsp_cnt)) &&
                         (rsp_i.result == expected_i[rsp_cnt]);
                    if (!ok) begin
                        $display("Error at %0t ns: test %0d got %0d/%h want %0d/%h",
                                 $time, rsp_cnt, rsp_i.trans_id, rsp_i.result,
                                 rsp_cnt[`TRANS_ID_BITS-1:0], expected_i[rsp_cnt]);
                        errors++;
                    end
                    $display("test %0d %s", rsp_cnt, ok ? "ok" : "wrong");
                    rsp_cnt++;
                end
            end
        end
    end

    // end of run checks on kills and credits, then the count line
    task automatic print_summary();
        if (kills != expected_kills_i) begin
            $display("the cache saw %0d killed requests instead of %0d", kills, expected_kills_i);
            errors++;
        end
        if (outstanding != 0) begin
            $display("%0d credits did not return to the producer", outstanding);
            errors++;
        end
        $display("%0d of %0d tests completed, %0d errors", rsp_cnt, n_lines, errors);
    endtask

endmodule

`default_nettype wire

// ==== tb/load_testdata.mem ====
// columns: op (0 LD 1 LW 2 LWU 3 LH 4 LHU 5 LB 6 LBU), vaddr, cache word,
// tlb miss flag, page offset stall cycles, expected result
0_00001000_8192a3b4c5d6e7f8_0_0_8192a3b4c5d6e7f8
1_00001008_8192a3b4c5d6e7f8_0_0_ffffffffc5d6e7f8
2_00001010_8192a3b4c5d6e7f8_0_0_00000000c5d6e7f8
3_00001018_8192a3b4c5d6e7f8_0_0_ffffffffffffe7f8
4_00001020_8192a3b4c5d6e7f8_0_0_000000000000e7f8
5_00001028_8192a3b4c5d6e7f8_0_0_fffffffffffffff8
6_00001030_8192a3b4c5d6e7f8_0_0_00000000000000f8
1_00002004_0123456789abcdef_0_0_0000000001234567
3_00002102_0123456789abcdef_0_0_ffffffffffff89ab
5_00002203_0123456789abcdef_0_0_ffffffffffffff89
4_00003006_0123456789abcdef_1_0_0000000000000123
1_00003100_8192a3b4c5d6e7f8_0_3_ffffffffc5d6e7f8
0_00003200_0123456789abcdef_1_0_0123456789abcdef
6_00003305_8192a3b4c5d6e7f8_0_2_00000000000000a3

// ==== tb/tb_load_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "load_macros.svh"

module tb_load_unit
    import load_pkg::*;
();

    localparam int n_lines = 14;

    logic [171:0] lines [n_lines];
    xlen_t        expected [n_lines];
    vaddr_t       addrs [n_lines];
    logic [2:0]   ops [n_lines];
    int           expected_kills;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    load_req_t   req;
    logic        credit;
    logic        translation_req;
    vaddr_t      vaddr;
    logic        dtlb_hit;
    paddr_t      paddr;
    index_t      page_offset;
    logic        page_offset_matches;
    dcache_req_t dcache_req;
    dcache_rsp_t dcache_rsp;
    load_rsp_t   rsp;
    logic        done;
    int          errors;

    // model state
    logic [31:0] lfsr;
    int          credits;
    int          next_line;
    int          gap;
    int          pop_cnt;
    int          tag_cnt;
    int          idx;
    int          stall_left;
    logic [1:0]  gnt_wait;
    logic [1:0]  gnt_delay;
    logic [1:0]  draw;
    logic        gnt;
    logic        miss_now;
    logic        rvalid_q;
    xlen_t       rdata_q;
    logic        miss_used [n_lines];
    logic        stall_started [n_lines];

    // fields of one data line
    function automatic logic [2:0] line_op(int i);
        return lines[i][170:168];
    endfunction

    function automatic vaddr_t line_addr(int i);
        return lines[i][167:136];
    endfunction

    function automatic xlen_t line_word(int i);
        return lines[i][135:72];
    endfunction

    function automatic logic line_miss(int i);
        return lines[i][68];
    endfunction

    function automatic int line_stall(int i);
        return int'(lines[i][67:64]);
    endfunction

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_two_bits(output logic [1:0] v);
        v = 2'b00;
        for (int k = 0; k < 2; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[0], lfsr[0]};
        end
    endtask

    load_unit_top u_load_unit_top (
        .clk_i                 (clk),
        .rst_ni                (rst_n),
        .req_valid_i           (req_valid),
        .req_i                 (req),
        .credit_o              (credit),
        .translation_req_o     (translation_req),
        .vaddr_o               (vaddr),
        .dtlb_hit_i            (dtlb_hit),
        .paddr_i               (paddr),
        .page_offset_o         (page_offset),
        .page_offset_matches_i (page_offset_matches),
        .dcache_req_o          (dcache_req),
        .dcache_rsp_i          (dcache_rsp),
        .rsp_o                 (rsp)
    );

    load_checker #(.n_lines(n_lines)) u_checker (
        .clk_i                 (clk),
        .rst_ni                (rst_n),
        .req_valid_i           (req_valid),
        .credit_i              (credit),
        .translation_req_i     (translation_req),
        .vaddr_i               (vaddr),
        .page_offset_i         (page_offset),
        .dcache_req_i          (dcache_req),
        .page_offset_matches_i (page_offset_matches),
        .rsp_i                 (rsp),
        .addr_i                (addrs),
        .op_i                  (ops),
        .expected_i            (expected),
        .expected_kills_i      (expected_kills),
        .done_o                (done),
        .error_count_o         (errors)
    );

    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // TLB, alias and cache models answering in the same cycle
    // ------------------------------------------------------------------------
    always_comb begin
        // the head of the buffer is always the next line not yet popped
        idx      = (pop_cnt < n_lines) ? pop_cnt : n_lines - 1;
        gnt      = dcache_req.data_req && (gnt_wait == gnt_delay);
        // a miss line misses once, on its first granted translation
        miss_now = line_miss(idx) && !miss_used[idx] && gnt;
        dtlb_hit = translation_req && !miss_now;
        paddr    = {2'b00, vaddr};
        page_offset_matches = (stall_left > 0) ||
            (translation_req && !stall_started[idx] && (line_stall(idx) != 0));
        dcache_rsp = '{data_gnt: gnt, data_rvalid: rvalid_q, data_rdata: rdata_q};
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr       = 32'hfbd406b3;
            credits    = `REQ_DEPTH;
            next_line  = 0;
            gap        = 0;
            pop_cnt    <= 0;
            tag_cnt    <= 0;
            stall_left <= 0;
            gnt_wait   <= '0;
            gnt_delay  <= '0;
            rvalid_q   <= 1'b0;
            rdata_q    <= '0;
            req_valid  <= 1'b0;
            for (int i = 0; i < n_lines; i++) begin
                miss_used[i]     <= 1'b0;
                stall_started[i] <= 1'b0;
            end
        end else begin
            // a credit returned in the last cycle can be spent at once
            credits = credits + int'(credit);
            if (next_line < n_lines && credits > 0 && gap == 0) begin
                req_valid <= 1'b1;
                req       <= '{trans_id: trans_id_t'(next_line), vaddr: line_addr(next_line),
                               op: load_op_e'(line_op(next_line))};
                next_line = next_line + 1;
                credits   = credits - 1;
                take_two_bits(draw);
                gap = (draw == 2'b11) ? 2 : 0;
            end else begin
                req_valid <= 1'b0;
                if (gap > 0) begin
                    gap = gap - 1;
                end
            end

            // grant after a random delay of zero to three cycles
            if (dcache_req.data_req) begin
                if (gnt) begin
                    gnt_wait <= '0;
                    take_two_bits(draw);
                    gnt_delay <= draw;
                end else begin
                    gnt_wait <= gnt_wait + 2'd1;
                end
            end
            if (miss_now) begin
                miss_used[idx] <= 1'b1;
            end

            // the alias stall starts with the first translation request of a line
            if (translation_req && !stall_started[idx]) begin
                stall_started[idx] <= 1'b1;
                stall_left <= (line_stall(idx) == 0) ? 0 : line_stall(idx) - 1;
            end else if (stall_left > 0) begin
                stall_left <= stall_left - 1;
            end
            if (credit) begin
                pop_cnt <= pop_cnt + 1;
            end

            // data returns one cycle after a tag that was not killed
            rvalid_q <= dcache_req.tag_valid && !dcache_req.kill_req;
            if (dcache_req.tag_valid && !dcache_req.kill_req) begin
                rdata_q <= line_word((tag_cnt < n_lines) ? tag_cnt : n_lines - 1);
                tag_cnt <= tag_cnt + 1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // reset, run and result
    // ------------------------------------------------------------------------
    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        $readmemh("tb/load_testdata.mem", lines);
        expected_kills = 0;
        for (int i = 0; i < n_lines; i++) begin
            expected[i] = lines[i][63:0];
            addrs[i]    = line_addr(i);
            ops[i]      = line_op(i);
            expected_kills = expected_kills + int'(line_miss(i));
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        while (!done) begin
            @(posedge clk);
        end
        // let the last credit come home before the final count
        repeat (4) @(posedge clk);
        u_checker.print_summary();
        @(posedge clk);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // the run may take at most 200 cycles for each data line
    initial begin
        repeat (200 * n_lines) @(posedge clk);
        $display("timeout: not all loads completed within %0d cycles", 200 * n_lines);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
